//--- sim.f
+incdir+source
source/block_looper_pkg.sv
source/grid_offset_walker.sv
source/group_rotation_arbiter.sv
source/pending_block_counter.sv
source/unit_dispatch_slot.sv
source/parallel_block_looper.sv
verification/tb_parallel_block_looper.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the parallel block looper testbench with Verilator.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

TOP=tb_parallel_block_looper
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing -j 0 --top-module "$TOP" -Mdir "$BUILD_DIR" -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation finished"
exit 0

//--- verification/tb_parallel_block_looper.sv
/*
 * Parallel block looper testbench
 * Runs a series of jobs through the looper with randomly stalling unit
 * models, checks each dispatched command against a reference model,
 * and checks the pending limit and job completion.
 */
`timescale 1ns/1ps
`include "block_looper_params.svh"

module tb_parallel_block_looper
	import block_looper_pkg::*;
();

localparam int CLK_PERIOD = 8;
localparam int N_JOBS = 4;
// Worst case cycles per base block under heavy stalls
localparam int CYCLE_BOUND = 400;

logic      i_clk;
logic      i_rst_n;
logic      i_job_rdy;
logic      o_job_ack;
grid_cfg_t i_grid_cfg;
sys_cfg_t  i_sys_cfg;
unit_vec_t o_unit_rdy;
unit_vec_t i_unit_ack = '0;
unit_vec_t i_unit_done = '0;
unit_cmd_t o_unit_cmd [`BL_N_UNIT];

sys_cfg_t    cur_s;
int          ack_pct = 0;
int          max_dly = 1;
int          cyc = 0;
int          ack_cnt = 0;
int          outst [`BL_N_UNIT] = '{default: 0};
int          due_q [`BL_N_UNIT][$];
unit_cmd_t   exp_q [$];
int unsigned lcg_state = 32'd95765;

parallel_block_looper dut_i (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_job_rdy   (i_job_rdy),
	.o_job_ack   (o_job_ack),
	.i_grid_cfg  (i_grid_cfg),
	.i_sys_cfg   (i_sys_cfg),
	.o_unit_rdy  (o_unit_rdy),
	.i_unit_ack  (i_unit_ack),
	.o_unit_cmd  (o_unit_cmd),
	.i_unit_done (i_unit_done)
);

initial begin
	i_clk = 1'b0;
	forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

function automatic int unsigned next_rand();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state >> 16;
endfunction

task automatic check_eq(input int got, input int exp, input string what);
	if (got !== exp) begin
		$display("ERROR at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
		$display("ERRORS FOUND");
		$fatal(1, "Mismatch detected");
	end
endtask

// ==================================================
// Job table and reference model
// ==================================================
function automatic ofs_vec_t make_vec(input int a0, input int a1);
	ofs_vec_t v;
	v[0] = work_t'(a0);
	v[1] = work_t'(a1);
	return v;
endfunction

function automatic void job_setup(input int n, output grid_cfg_t g, output sys_cfg_t s,
	output int ap, output int md);
	case (n)
		0: begin
			g.step = make_vec(1, 2);
			g.stop = make_vec(3, 4);
			g.bound = make_vec(100, 100);
			s = {2'b11, 2'b11};
			ap = 100;
			md = 3;
		end
		1: begin
			// i0 systolic on axis 0
			g.step = make_vec(2, 1);
			g.stop = make_vec(6, 2);
			g.bound = make_vec(100, 100);
			s = {2'd0, 2'b11};
			ap = 70;
			md = 6;
		end
		2: begin
			// Whole array with the last column clipped on the second row of bases
			g.step = make_vec(1, 1);
			g.stop = make_vec(2, 2);
			g.bound = make_vec(100, 3);
			s = {2'd0, 2'd1};
			ap = 60;
			md = 8;
		end
		default: begin
			// i1 systolic on axis 0 under heavy back-pressure
			g.step = make_vec(1, 1);
			g.stop = make_vec(3, 3);
			g.bound = make_vec(5, 100);
			s = {2'b11, 2'd0};
			ap = 25;
			md = 24;
		end
	endcase
endfunction

function automatic int base_count(input grid_cfg_t g);
	int n0;
	int n1;
	n0 = (int'(g.stop[0]) + int'(g.step[0]) - 1) / int'(g.step[0]);
	n1 = (int'(g.stop[1]) + int'(g.step[1]) - 1) / int'(g.step[1]);
	return n0 * n1;
endfunction

function automatic int axis_ofs(input int b, input int step, input int k, input int i,
	input int j, input sys_cfg_t s);
	if (k == int'(s.i0_axis)) begin
		return b * `BL_N_X + i * step;
	end
	if (k == int'(s.i1_axis)) begin
		return b * `BL_N_Y + j * step;
	end
	return b;
endfunction

function automatic bit unit_inside(input int b0, input int b1, input int i, input int j,
	input grid_cfg_t g, input sys_cfg_t s);
	for (int k = 0; k < `BL_VDIM; k++) begin
		if (axis_ofs((k == 0) ? b0 : b1, int'(g.step[k]), k, i, j, s) >= int'(g.bound[k])) begin
			return 1'b0;
		end
	end
	return 1'b1;
endfunction

function automatic unit_cmd_t expected_cmd(input int b0, input int b1, input int i,
	input int j, input grid_cfg_t g, input sys_cfg_t s);
	unit_cmd_t c;
	int        n0;
	int        n1;
	n0 = 0;
	n1 = 0;
	for (int x = 0; x < `BL_N_X; x++) begin
		n0 = n0 + int'(unit_inside(b0, b1, x, 0, g, s));
	end
	for (int y = 0; y < `BL_N_Y; y++) begin
		n1 = n1 + int'(unit_inside(b0, b1, 0, y, g, s));
	end
	for (int k = 0; k < `BL_VDIM; k++) begin
		c.ofs[k] = work_t'(axis_ofs((k == 0) ? b0 : b1, int'(g.step[k]), k, i, j, s));
	end
	c.i0_gsize = (s.i0_axis == 2'b11) ? gsize_t'(1) : gsize_t'(n0);
	c.i1_gsize = (s.i1_axis == 2'b11) ? gsize_t'(1) : gsize_t'(n1);
	c.i0_idx = (s.i0_axis == 2'b11) ? '0 : sidx_t'(i);
	c.i1_idx = (s.i1_axis == 2'b11) ? '0 : sidx_t'(j);
	return c;
endfunction

// One entry per base and per group role along the systolic axes
function automatic void build_expected(input grid_cfg_t g, input sys_cfg_t s);
	int ni;
	int nj;
	ni = (s.i0_axis == 2'b11) ? 1 : `BL_N_X;
	nj = (s.i1_axis == 2'b11) ? 1 : `BL_N_Y;
	for (int b1 = 0; b1 < int'(g.stop[1]); b1 += int'(g.step[1])) begin
		for (int b0 = 0; b0 < int'(g.stop[0]); b0 += int'(g.step[0])) begin
			for (int i = 0; i < ni; i++) begin
				for (int j = 0; j < nj; j++) begin
					if (unit_inside(b0, b1, i, j, g, s)) begin
						exp_q.push_back(expected_cmd(b0, b1, i, j, g, s));
					end
				end
			end
		end
	end
endfunction

// ==================================================
// Unit models and monitor
// ==================================================
always @(posedge i_clk) begin
	#1;
	cyc++;
	for (int u = 0; u < `BL_N_UNIT; u++) begin
		i_unit_ack[u] = int'(next_rand() % 100) < ack_pct;
		i_unit_done[u] = 1'b0;
		if (due_q[u].size() > 0 && due_q[u][0] <= cyc) begin
			i_unit_done[u] = 1'b1;
			void'(due_q[u].pop_front());
		end
	end
end

always @(negedge i_clk) begin
	int hit;
	int i;
	int j;
	if (i_rst_n) begin
		if (o_job_ack) begin
			ack_cnt++;
			check_eq(exp_q.size(), 0, "blocks never dispatched at job ack");
			for (int u = 0; u < `BL_N_UNIT; u++) begin
				check_eq(outst[u], 0, $sformatf("unit %0d blocks not done at job ack", u));
			end
		end
		for (int u = 0; u < `BL_N_UNIT; u++) begin
			if (o_unit_rdy[u] && i_unit_ack[u]) begin
				i = u / `BL_N_Y;
				j = u % `BL_N_Y;
				check_eq(int'(o_unit_cmd[u].i0_idx), (cur_s.i0_axis == 2'b11) ? 0 : i,
					$sformatf("i0 index on unit %0d", u));
				check_eq(int'(o_unit_cmd[u].i1_idx), (cur_s.i1_axis == 2'b11) ? 0 : j,
					$sformatf("i1 index on unit %0d", u));
				hit = -1;
				foreach (exp_q[k]) begin
					if (hit < 0 && exp_q[k] == o_unit_cmd[u]) begin
						hit = k;
					end
				end
				check_eq(int'(hit >= 0), 1,
					$sformatf("unexpected command %0h on unit %0d", o_unit_cmd[u], u));
				exp_q.delete(hit);
				outst[u]++;
				due_q[u].push_back(cyc + 1 + int'(next_rand() % max_dly));
			end
			if (i_unit_done[u]) begin
				outst[u]--;
			end
			check_eq(int'(outst[u] > `BL_MAX_PENDING), 0,
				$sformatf("pending limit exceeded on unit %0d", u));
		end
	end
end

// ==================================================
// Job driver and watchdog
// ==================================================
initial begin
	grid_cfg_t g;
	sys_cfg_t  s;
	int        ap;
	int        md;
	i_rst_n = 1'b0;
	i_job_rdy = 1'b0;
	i_grid_cfg = '0;
	i_sys_cfg = '1;
	cur_s = '1;
	repeat (16) @(posedge i_clk);
	#1 i_rst_n = 1'b1;
	for (int n = 0; n < N_JOBS; n++) begin
		job_setup(n, g, s, ap, md);
		@(negedge i_clk);
		cur_s = s;
		ack_pct = ap;
		max_dly = md;
		build_expected(g, s);
		@(posedge i_clk);
		#1;
		i_grid_cfg = g;
		i_sys_cfg = s;
		i_job_rdy = 1'b1;
		@(negedge i_clk);
		while (!o_job_ack) @(negedge i_clk);
		@(posedge i_clk);
		#1 i_job_rdy = 1'b0;
		repeat (4) @(posedge i_clk);
		check_eq(ack_cnt, n + 1, $sformatf("job acknowledge count after job %0d", n));
	end
	$display("NO ERRORS");
	$finish;
end

initial begin
	grid_cfg_t g;
	sys_cfg_t  s;
	int        ap;
	int        md;
	int        bases;
	bases = 0;
	for (int n = 0; n < N_JOBS; n++) begin
		job_setup(n, g, s, ap, md);
		bases += base_count(g);
	end
	#((16 + bases * CYCLE_BOUND) * CLK_PERIOD);
	$display("ERRORS FOUND");
	$fatal(1, "Watchdog timeout, the jobs did not complete in time");
end

endmodule

//--- source/parallel_block_looper.sv
/*
 * Parallel block looper
 * Walks a job's block grid and sends each base block to one group of
 * processing units, spreading the offset over the systolic axes and
 * skipping members past the boundary. Acknowledges the job once every
 * block has been taken and reported done.
 */
`timescale 1ns/1ps
`include "block_looper_params.svh"

module parallel_block_looper
	import block_looper_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_job_rdy,
	output logic      o_job_ack,
	input  grid_cfg_t i_grid_cfg,
	input  sys_cfg_t  i_sys_cfg,
	output unit_vec_t o_unit_rdy,
	input  unit_vec_t i_unit_ack,
	output unit_cmd_t o_unit_cmd [`BL_N_UNIT],
	input  unit_vec_t i_unit_done
);

logic      i0_en;
logic      i1_en;
logic      base_rdy;
logic      base_ack;
logic      walk_done;
logic      grant_any;
ofs_vec_t  base_ofs;
ofs_vec_t  unit_ofs [`BL_N_UNIT];
unit_vec_t unit_valid;
unit_vec_t grant;
unit_vec_t load;
unit_vec_t busy;
unit_vec_t idle;
gsize_t    i0_gsize;
gsize_t    i1_gsize;
unit_cmd_t unit_cmd [`BL_N_UNIT];

// ==================================================
// Offset spreading and boundary check
// ==================================================
always_comb begin
	i0_en = i_sys_cfg.i0_axis != '1;
	i1_en = i_sys_cfg.i1_axis != '1;
	for (int i = 0; i < `BL_N_X; i++) begin
		for (int j = 0; j < `BL_N_Y; j++) begin
			unit_valid[i*`BL_N_Y+j] = 1'b1;
			for (int k = 0; k < `BL_VDIM; k++) begin
				if (k == int'(i_sys_cfg.i0_axis)) begin
					unit_ofs[i*`BL_N_Y+j][k] = work_t'(base_ofs[k] * `BL_N_X
						+ i * i_grid_cfg.step[k]);
				end else if (k == int'(i_sys_cfg.i1_axis)) begin
					unit_ofs[i*`BL_N_Y+j][k] = work_t'(base_ofs[k] * `BL_N_Y
						+ j * i_grid_cfg.step[k]);
				end else begin
					unit_ofs[i*`BL_N_Y+j][k] = base_ofs[k];
				end
				if (unit_ofs[i*`BL_N_Y+j][k] >= i_grid_cfg.bound[k]) begin
					unit_valid[i*`BL_N_Y+j] = 1'b0;
				end
			end
		end
	end
end

// Group sizes count the valid members along each systolic axis
always_comb begin
	i0_gsize = '0;
	i1_gsize = '0;
	for (int i = 0; i < `BL_N_X; i++) begin
		i0_gsize = i0_gsize + gsize_t'(unit_valid[i*`BL_N_Y]);
	end
	for (int j = 0; j < `BL_N_Y; j++) begin
		i1_gsize = i1_gsize + gsize_t'(unit_valid[j]);
	end
	if (!i0_en) begin
		i0_gsize = gsize_t'(1);
	end
	if (!i1_en) begin
		i1_gsize = gsize_t'(1);
	end
end

always_comb begin
	for (int i = 0; i < `BL_N_X; i++) begin
		for (int j = 0; j < `BL_N_Y; j++) begin
			unit_cmd[i*`BL_N_Y+j].ofs = unit_ofs[i*`BL_N_Y+j];
			unit_cmd[i*`BL_N_Y+j].i0_gsize = i0_gsize;
			unit_cmd[i*`BL_N_Y+j].i0_idx = i0_en ? sidx_t'(i) : '0;
			unit_cmd[i*`BL_N_Y+j].i1_gsize = i1_gsize;
			unit_cmd[i*`BL_N_Y+j].i1_idx = i1_en ? sidx_t'(j) : '0;
		end
	end
end

// ==================================================
// Handshakes and completion
// ==================================================
assign base_ack = base_rdy && grant_any;
assign load = grant & unit_valid;
assign o_job_ack = i_job_rdy && walk_done && (&idle);

grid_offset_walker u_walker (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_start     (i_job_rdy),
	.i_step      (i_grid_cfg.step),
	.i_end       (i_grid_cfg.stop),
	.i_base_ack  (base_ack),
	.i_job_ack   (o_job_ack),
	.o_base_rdy  (base_rdy),
	.o_base_ofs  (base_ofs),
	.o_walk_done (walk_done)
);

group_rotation_arbiter u_arb (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_sys       (i_sys_cfg),
	.i_req       (base_rdy),
	.i_free      (~busy),
	.i_valid     (unit_valid),
	.o_grant     (grant),
	.o_grant_any (grant_any)
);

generate
	for (genvar u = 0; u < `BL_N_UNIT; u++) begin : g_unit
		unit_dispatch_slot u_slot (
			.i_clk       (i_clk),
			.i_rst_n     (i_rst_n),
			.i_load      (load[u]),
			.i_cmd       (unit_cmd[u]),
			.i_unit_ack  (i_unit_ack[u]),
			.i_unit_done (i_unit_done[u]),
			.o_unit_rdy  (o_unit_rdy[u]),
			.o_unit_cmd  (o_unit_cmd[u]),
			.o_busy      (busy[u]),
			.o_idle      (idle[u])
		);
	end
endgenerate

endmodule

//--- source/unit_dispatch_slot.sv
/*
 * Unit dispatch slot
 * Holds one command for a processing unit from load until the unit
 * takes it, pausing while the unit has too many blocks in flight.
 */
`timescale 1ns/1ps
`include "block_looper_params.svh"

module unit_dispatch_slot
	import block_looper_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_load,
	input  unit_cmd_t i_cmd,
	input  logic      i_unit_ack,
	input  logic      i_unit_done,
	output logic      o_unit_rdy,
	output unit_cmd_t o_unit_cmd,
	output logic      o_busy,
	output logic      o_idle
);

logic      loaded_r;
unit_cmd_t cmd_r;
logic      pend_full;
logic      pend_empty;
logic      xfer;

// Hidden from the unit while its pending count is full
assign o_unit_rdy = loaded_r && !pend_full;
assign xfer = o_unit_rdy && i_unit_ack;
assign o_unit_cmd = cmd_r;
assign o_busy = loaded_r;
assign o_idle = !loaded_r && pend_empty;

always_ff @(posedge i_clk) begin
	if (!i_rst_n) begin
		loaded_r <= 1'b0;
	end else if (i_load) begin
		loaded_r <= 1'b1;
	end else if (xfer) begin
		loaded_r <= 1'b0;
	end
end

always_ff @(posedge i_clk) begin
	if (i_load) begin
		cmd_r <= i_cmd;
	end
end

pending_block_counter u_pending (
	.i_clk   (i_clk),
	.i_rst_n (i_rst_n),
	.i_inc   (xfer),
	.i_dec   (i_unit_done),
	.o_full  (pend_full),
	.o_empty (pend_empty)
);

endmodule

//--- source/pending_block_counter.sv
/*
 * Pending block counter
 * Counts blocks a unit has accepted but not yet reported done,
 * saturating at the pending limit.
 */
`timescale 1ns/1ps
`include "block_looper_params.svh"

module pending_block_counter (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_inc,
	input  logic i_dec,
	output logic o_full,
	output logic o_empty
);

localparam int CNT_BW = $clog2(`BL_MAX_PENDING + 1);

logic [CNT_BW-1:0] cnt_r;

assign o_full = cnt_r == CNT_BW'(`BL_MAX_PENDING);
assign o_empty = cnt_r == '0;

// Increment and decrement together cancel out
always_ff @(posedge i_clk) begin
	if (!i_rst_n) begin
		cnt_r <= '0;
	end else if (i_inc && !i_dec) begin
		if (!o_full) begin
			cnt_r <= cnt_r + 1'b1;
		end
	end else if (i_dec && !i_inc) begin
		if (!o_empty) begin
			cnt_r <= cnt_r - 1'b1;
		end
	end
end

endmodule

//--- source/group_rotation_arbiter.sv
/*
 * Group rotation arbiter
 * Merges units into systolic groups, picks the first free group from a
 * rotating pointer and grants all of its members at once.
 */
`timescale 1ns/1ps
`include "block_looper_params.svh"

module group_rotation_arbiter
	import block_looper_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  sys_cfg_t  i_sys,
	input  logic      i_req,
	input  unit_vec_t i_free,
	input  unit_vec_t i_valid,
	output unit_vec_t o_grant,
	output logic      o_grant_any
);

localparam int PTR_BW = $clog2(`BL_N_UNIT);

logic                  i0_en;
logic                  i1_en;
logic [PTR_BW-1:0]     grp_mask;
logic [PTR_BW-1:0]     ptr_r;
logic [PTR_BW-1:0]     idx;
logic [PTR_BW-1:0]     sel;
logic [`BL_N_UNIT-1:0] grp_ok;
logic                  none_valid;
logic                  found;
unit_vec_t             member [`BL_N_UNIT];

// ==================================================
// Group layout by systolic mode
// ==================================================
always_comb begin
	i0_en = i_sys.i0_axis != '1;
	i1_en = i_sys.i1_axis != '1;
	// Group counts are powers of two, so the wrap is a mask
	case ({i0_en, i1_en})
		2'b00:   grp_mask = PTR_BW'(`BL_N_UNIT - 1);
		2'b10:   grp_mask = PTR_BW'(`BL_N_Y - 1);
		2'b01:   grp_mask = PTR_BW'(`BL_N_X - 1);
		default: grp_mask = '0;
	endcase
	for (int g = 0; g < `BL_N_UNIT; g++) begin
		member[g] = '0;
	end
	for (int i = 0; i < `BL_N_X; i++) begin
		for (int j = 0; j < `BL_N_Y; j++) begin
			case ({i0_en, i1_en})
				2'b00:   member[i*`BL_N_Y+j][i*`BL_N_Y+j] = 1'b1;
				2'b10:   member[j][i*`BL_N_Y+j] = 1'b1;
				2'b01:   member[i][i*`BL_N_Y+j] = 1'b1;
				default: member[0][i*`BL_N_Y+j] = 1'b1;
			endcase
		end
	end
end

// ==================================================
// Free groups and rotating search
// ==================================================
always_comb begin
	// A base clipped on every unit still has to be consumed
	none_valid = ~|i_valid;
	for (int g = 0; g < `BL_N_UNIT; g++) begin
		grp_ok[g] = (g <= int'(grp_mask))
			&& (&(i_free | ~i_valid | ~member[g]))
			&& ((|(member[g] & i_valid)) || none_valid);
	end
	found = 1'b0;
	sel = ptr_r & grp_mask;
	for (int k = 0; k < `BL_N_UNIT; k++) begin
		idx = (ptr_r + PTR_BW'(k)) & grp_mask;
		if (!found && grp_ok[idx]) begin
			found = 1'b1;
			sel = idx;
		end
	end
	o_grant_any = i_req && found;
	o_grant = o_grant_any ? member[sel] : '0;
end

always_ff @(posedge i_clk) begin
	if (!i_rst_n) begin
		ptr_r <= '0;
	end else if (o_grant_any && grp_mask != '0) begin
		ptr_r <= (ptr_r + 1'b1) & grp_mask;
	end
end

endmodule

//--- source/grid_offset_walker.sv
/*
 * Grid offset walker
 * Steps the base block offset over a two-axis grid, axis 0 innermost,
 * offering each base under rdy/ack. Holds in DRAIN after the last base
 * until the job is acknowledged.
 */
`timescale 1ns/1ps
`include "block_looper_params.svh"

module grid_offset_walker
	import block_looper_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_start,
	input  ofs_vec_t i_step,
	input  ofs_vec_t i_end,
	input  logic     i_base_ack,
	input  logic     i_job_ack,
	output logic     o_base_rdy,
	output ofs_vec_t o_base_ofs,
	output logic     o_walk_done
);

walker_state_e state_r;
walker_state_e state_w;
ofs_vec_t      ofs_r;
ofs_vec_t      ofs_w;
// One extra bit so a large step cannot wrap past the end
logic [`BL_WORK_BW:0] nxt0;
logic [`BL_WORK_BW:0] nxt1;
logic                 last0;
logic                 last1;

always_comb begin
	nxt0 = {1'b0, ofs_r[0]} + {1'b0, i_step[0]};
	nxt1 = {1'b0, ofs_r[1]} + {1'b0, i_step[1]};
	last0 = nxt0 >= {1'b0, i_end[0]};
	last1 = nxt1 >= {1'b0, i_end[1]};
	state_w = state_r;
	ofs_w = ofs_r;
	case (state_r)
		IDLE: begin
			if (i_start) begin
				state_w = WALK;
				ofs_w = '0;
			end
		end
		WALK: begin
			if (i_base_ack) begin
				if (last0) begin
					ofs_w[0] = '0;
					if (last1) begin
						state_w = DRAIN;
					end else begin
						ofs_w[1] = nxt1[`BL_WORK_BW-1:0];
					end
				end else begin
					ofs_w[0] = nxt0[`BL_WORK_BW-1:0];
				end
			end
		end
		DRAIN: begin
			if (i_job_ack) begin
				state_w = IDLE;
			end
		end
		default: state_w = IDLE;
	endcase
end

always_ff @(posedge i_clk) begin
	if (!i_rst_n) begin
		state_r <= IDLE;
	end else begin
		state_r <= state_w;
	end
	ofs_r <= ofs_w;
end

assign o_base_rdy = state_r == WALK;
assign o_base_ofs = ofs_r;
assign o_walk_done = state_r == DRAIN;

endmodule

//--- source/block_looper_pkg.sv
/*
 * Parallel block looper types
 * Offset vectors, job configuration and per-unit command records
 * shared by the looper RTL and its testbench.
 */
`include "block_looper_params.svh"

package block_looper_pkg;

	typedef logic [`BL_WORK_BW-1:0] work_t;
	typedef logic [`BL_AXIS_BW-1:0] axis_t;
	// Index 0 is axis 0
	typedef work_t [`BL_VDIM-1:0] ofs_vec_t;

	typedef struct packed {
		ofs_vec_t step;
		ofs_vec_t stop;
		ofs_vec_t bound;
	} grid_cfg_t;

	typedef struct packed {
		axis_t i0_axis;
		axis_t i1_axis;
	} sys_cfg_t;

	typedef logic [$clog2(`BL_N_X+1)-1:0] gsize_t;
	typedef logic [$clog2(`BL_N_X)-1:0]   sidx_t;

	typedef struct packed {
		ofs_vec_t ofs;
		gsize_t   i0_gsize;
		sidx_t    i0_idx;
		gsize_t   i1_gsize;
		sidx_t    i1_idx;
	} unit_cmd_t;

	// Unit (i, j) sits at bit i*BL_N_Y+j
	typedef logic [`BL_N_UNIT-1:0] unit_vec_t;

	typedef enum logic [1:0] {IDLE, WALK, DRAIN} walker_state_e;

endpackage

//--- source/block_looper_params.svh
/*
 * Parallel block looper parameters
 * Grid dimension, word width, processing unit array size and the
 * per-unit limit on blocks that are dispatched but not yet done.
 */
`ifndef BLOCK_LOOPER_PARAMS_SVH
`define BLOCK_LOOPER_PARAMS_SVH

// Number of grid axes
`define BL_VDIM 2
// Width of one offset or step word
`define BL_WORK_BW 16

// Unit array with i0 along x and i1 along y
`define BL_N_X 2
`define BL_N_Y 2
`define BL_N_UNIT 4

// Outstanding blocks allowed per unit
`define BL_MAX_PENDING 2

// Axis selector width where all ones means not systolic
`define BL_AXIS_BW 2

`endif
